// File: matMulCore_settings.svh
`ifndef MATMUL_CORE_SETTINGS_SVH
`define MATMUL_CORE_SETTINGS_SVH

// Register, immediate and store word width
`define MATMUL_DATA_WIDTH 8

// Instruction FIFO entries, equal to the credits the source starts with
`define MATMUL_INSTR_DEPTH 4

// Store record buffer entries
`define MATMUL_STORE_DEPTH 4

// Store credits held by the core after reset
`define MATMUL_STORE_CREDITS 2

`endif

// File: matMulPkg.sv
`include "matMulCore_settings.svh"

package matMulPkg;

    typedef logic [`MATMUL_DATA_WIDTH-1:0] dataT;

    // Upper nibble opcode, lower nibble variant
    typedef logic [7:0] instrByteT;

    typedef enum logic [3:0] {
        opNoop   = 4'h0,
        opAssign = 4'h1, // Followed by one immediate byte
        opMove   = 4'h2,
        opSet    = 4'h3,
        opAdd    = 4'h4,
        opMul    = 4'h5,
        opInc    = 4'h6,
        opReset  = 4'h7,
        opStore  = 4'h8
    } opcodeE;

    typedef enum logic [3:0] {
        varC1  = 4'h0,
        varC2  = 4'h1,
        varC3  = 4'h2,
        varP   = 4'h3,
        varT   = 4'h4,
        varM2  = 4'h5,
        varAll = 4'h6
    } variantE;

    // One operation as handed from decoder to execute
    typedef struct packed {
        opcodeE  opcode;
        variantE variant;
        dataT    imm;     // Zero unless ASSIGN
    } decodedOpT;

    // STORE result, address from C3 and data from T
    typedef struct packed {
        dataT addr;
        dataT data;
    } storeRecT;

endpackage

// File: creditFifo.sv
`timescale 1ns/100ps
`include "matMulCore_settings.svh"

module creditFifo #(
    parameter type payloadT = logic [7:0],
    parameter int  depth    = `MATMUL_INSTR_DEPTH
) (
    input  logic    Clk,
    input  logic    rstN,
    input  logic    push,
    input  payloadT pushData,
    input  logic    pop,
    output payloadT popData,
    output logic    empty,
    output logic    full
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    payloadT         mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;

    // Wrap at depth, which need not be a power of two
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == cntW'(depth));
    assign popData = mem[rdPtr]; // Show-ahead read

    always_ff @(posedge Clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // The sender's credit accounting must keep us from ever filling past depth
    noOverflow: assert property (@(posedge Clk) disable iff (!rstN) !(push && full));
    noUnderflow: assert property (@(posedge Clk) disable iff (!rstN) !(pop && empty));

endmodule

// File: instrDecoder.sv
`timescale 1ns/100ps
`include "matMulCore_settings.svh"

module instrDecoder (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  matMulPkg::instrByteT instrByte,
    output logic                 instrCredit,
    output logic                 opValid,
    output matMulPkg::decodedOpT op,
    input  logic                 opReady
);

    matMulPkg::instrByteT fifoByte;
    matMulPkg::instrByteT heldByte; // ASSIGN opcode waiting for its immediate
    logic                 fifoEmpty;
    logic                 pop;
    logic                 outFree;
    logic                 holdAssign;
    logic                 isAssign;

    creditFifo #(
        .payloadT (matMulPkg::instrByteT),
        .depth    (`MATMUL_INSTR_DEPTH)
    ) instrFifo_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .push     (instrValid),
        .pushData (instrByte),
        .pop      (pop),
        .popData  (fifoByte),
        .empty    (fifoEmpty),
        .full     ()
    );

    assign outFree  = !opValid || opReady;
    assign pop      = !fifoEmpty && outFree;
    assign isAssign = (fifoByte[7:4] == matMulPkg::opAssign);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            instrCredit <= 1'b0;
            opValid     <= 1'b0;
            holdAssign  <= 1'b0;
        end else begin
            instrCredit <= pop; // One credit back per byte removed
            if (opValid && opReady) opValid <= 1'b0;
            if (pop) begin
                if (holdAssign) begin
                    opValid    <= 1'b1; // Immediate arrived
                    holdAssign <= 1'b0;
                end else if (isAssign) begin
                    holdAssign <= 1'b1;
                end else begin
                    opValid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (pop) begin
            if (holdAssign) begin
                op.opcode  <= matMulPkg::opcodeE'(heldByte[7:4]);
                op.variant <= matMulPkg::variantE'(heldByte[3:0]);
                op.imm     <= matMulPkg::dataT'(fifoByte);
            end else begin
                op.opcode  <= matMulPkg::opcodeE'(fifoByte[7:4]);
                op.variant <= matMulPkg::variantE'(fifoByte[3:0]);
                op.imm     <= '0;
                heldByte   <= fifoByte;
            end
        end
    end

    // Execute may stall on store back-pressure, the op must wait untouched
    opHeldStable: assert property (@(posedge Clk) disable iff (!rstN)
        opValid && !opReady |=> opValid && $stable(op));

endmodule

// File: execUnit.sv
`timescale 1ns/100ps

module execUnit (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 opValid,
    input  matMulPkg::decodedOpT op,
    output logic                 opReady,
    output logic                 recValid,
    output matMulPkg::storeRecT  rec,
    input  logic                 recReady
);

    matMulPkg::dataT ac;
    matMulPkg::dataT p;
    matMulPkg::dataT t;
    matMulPkg::dataT c1;
    matMulPkg::dataT c2;
    matMulPkg::dataT c3;
    matMulPkg::dataT m2;
    logic            accept;

    // STORE leaves in the same cycle it is accepted
    assign recValid = opValid && (op.opcode == matMulPkg::opStore);
    assign rec.addr = c3;
    assign rec.data = t;

    // Only a STORE with no room in the result stage stalls
    assign opReady = !(recValid && !recReady);
    assign accept  = opValid && opReady;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            ac <= '0;
            p  <= '0;
            t  <= '0;
            c1 <= '0;
            c2 <= '0;
            c3 <= '0;
            m2 <= '0;
        end else if (accept) begin
            case (op.opcode)
                matMulPkg::opAssign: begin
                    case (op.variant)
                        matMulPkg::varC1: c1 <= op.imm;
                        matMulPkg::varC2: c2 <= op.imm;
                        matMulPkg::varC3: c3 <= op.imm;
                        default:          ;
                    endcase
                end
                matMulPkg::opMove: begin
                    case (op.variant)
                        matMulPkg::varP:  p  <= ac;
                        matMulPkg::varT:  t  <= ac;
                        matMulPkg::varC1: c1 <= ac;
                        default:          ;
                    endcase
                end
                matMulPkg::opSet: begin
                    if (op.variant == matMulPkg::varC1) ac <= c1;
                end
                matMulPkg::opAdd: begin
                    case (op.variant)
                        matMulPkg::varT:  ac <= ac + t;  // Wraps at data width
                        matMulPkg::varM2: ac <= ac + m2;
                        default:          ;
                    endcase
                end
                matMulPkg::opMul: begin
                    if (op.variant == matMulPkg::varP) ac <= p * ac; // Low half kept
                end
                matMulPkg::opInc: begin
                    case (op.variant)
                        matMulPkg::varC2: c2 <= c2 + 1'b1;
                        matMulPkg::varC3: c3 <= c3 + 1'b1;
                        matMulPkg::varM2: m2 <= m2 + 1'b1;
                        default:          ;
                    endcase
                end
                matMulPkg::opReset: begin
                    if (op.variant == matMulPkg::varAll) begin
                        t  <= '0;
                        m2 <= '0;
                        ac <= '0;
                    end
                end
                default: ; // NOOP, STORE and unknown opcodes leave registers alone
            endcase
        end
    end

endmodule

// File: storePort.sv
`timescale 1ns/100ps
`include "matMulCore_settings.svh"

module storePort (
    input  logic                Clk,
    input  logic                rstN,
    input  logic                recValid,
    input  matMulPkg::storeRecT rec,
    output logic                recReady,
    output logic                storeValid,
    output matMulPkg::dataT     storeAddr,
    output matMulPkg::dataT     storeData,
    input  logic                storeCredit
);

    localparam int creditW = $clog2(`MATMUL_STORE_CREDITS + 1);

    matMulPkg::storeRecT headRec;
    logic                fifoEmpty;
    logic                fifoFull;
    logic                send;
    logic [creditW-1:0]  credits;

    creditFifo #(
        .payloadT (matMulPkg::storeRecT),
        .depth    (`MATMUL_STORE_DEPTH)
    ) storeFifo_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .push     (recValid && recReady),
        .pushData (rec),
        .pop      (send),
        .popData  (headRec),
        .empty    (fifoEmpty),
        .full     (fifoFull)
    );

    assign recReady = !fifoFull;
    assign send     = !fifoEmpty && (credits != '0); // Oldest record, one credit

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            credits    <= creditW'(`MATMUL_STORE_CREDITS);
            storeValid <= 1'b0;
        end else begin
            storeValid <= send;
            case ({storeCredit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: ; // Returned and spent in the same cycle
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (send) begin
            storeAddr <= headRec.addr;
            storeData <= headRec.data;
        end
    end

    // Sink must never hand back more credits than it was given
    creditBound: assert property (@(posedge Clk) disable iff (!rstN)
        credits <= `MATMUL_STORE_CREDITS);

endmodule

// File: matMulCore.sv
`timescale 1ns/100ps
`include "matMulCore_settings.svh"

module matMulCore (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  matMulPkg::instrByteT instrByte,
    output logic                 instrCredit,
    output logic                 storeValid,
    output matMulPkg::dataT      storeAddr,
    output matMulPkg::dataT      storeData,
    input  logic                 storeCredit
);

    // Decoder to execute
    logic                 opValid;
    logic                 opReady;
    matMulPkg::decodedOpT op;

    // Execute to result stage
    logic                 recValid;
    logic                 recReady;
    matMulPkg::storeRecT  rec;

    instrDecoder instrDecoder_i (
        .Clk         (Clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instrByte   (instrByte),
        .instrCredit (instrCredit),
        .opValid     (opValid),
        .op          (op),
        .opReady     (opReady)
    );

    execUnit execUnit_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .opValid  (opValid),
        .op       (op),
        .opReady  (opReady),
        .recValid (recValid),
        .rec      (rec),
        .recReady (recReady)
    );

    storePort storePort_i (
        .Clk         (Clk),
        .rstN        (rstN),
        .recValid    (recValid),
        .rec         (rec),
        .recReady    (recReady),
        .storeValid  (storeValid),
        .storeAddr   (storeAddr),
        .storeData   (storeData),
        .storeCredit (storeCredit)
    );

endmodule

// File: matMulCore_tb.sv
`timescale 1ns/100ps
`include "matMulCore_settings.svh"

module matMulCore_tb;

    localparam int numRows   = 5;
    localparam int maxBytes  = 24;
    localparam int maxRecs   = 8;
    localparam int waitLimit = 400; // Cycles any single wait may take

    logic                 Clk;
    logic                 rstN;
    logic                 instrValid;
    matMulPkg::instrByteT instrByte;
    logic                 instrCredit;
    logic                 storeValid;
    matMulPkg::dataT      storeAddr;
    matMulPkg::dataT      storeData;
    logic                 storeCredit;

    // Stimulus table with one row per test
    string                 rowName   [numRows];
    logic [8*maxBytes-1:0] rowSeq    [numRows]; // First byte sits in the top used slot
    int                    rowLen    [numRows];
    bit                    rowGap    [numRows];
    int                    rowHold   [numRows]; // Cycles before store credits go back
    matMulPkg::storeRecT   rowExp    [numRows][maxRecs];
    int                    rowExpCnt [numRows];

    // Reference model registers
    matMulPkg::dataT mAc;
    matMulPkg::dataT mP;
    matMulPkg::dataT mT;
    matMulPkg::dataT mC1;
    matMulPkg::dataT mC2;
    matMulPkg::dataT mC3;
    matMulPkg::dataT mM2;

    matMulPkg::storeRecT received[$];
    int                  bytesSent;
    int                  creditPulses;
    int                  creditsReturned;
    int                  seed;

    matMulCore dut_i (
        .Clk         (Clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instrByte   (instrByte),
        .instrCredit (instrCredit),
        .storeValid  (storeValid),
        .storeAddr   (storeAddr),
        .storeData   (storeData),
        .storeCredit (storeCredit)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    task automatic abortRun();
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Outputs are stable around the falling edge
    always @(negedge Clk) begin
        if (rstN) begin
            if (instrCredit) creditPulses++;
            if (storeValid) begin
                received.push_back(matMulPkg::storeRecT'({storeAddr, storeData}));
                if (received.size() > creditsReturned + `MATMUL_STORE_CREDITS) begin
                    $display("Store record sent while the core held no store credit");
                    abortRun();
                end
            end
        end
    end

    task automatic compareStore(string name, matMulPkg::storeRecT expected,
                                matMulPkg::storeRecT actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected addr %02h data %02h, actual addr %02h data %02h",
                     name, expected.addr, expected.data, actual.addr, actual.data);
            abortRun();
        end
    endtask

    task automatic compareCredits(string name, int expected, int actual);
        if (actual != expected) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            abortRun();
        end
    endtask

    function automatic matMulPkg::instrByteT byteAt(int r, int i);
        return rowSeq[r][8*(rowLen[r]-1-i) +: 8];
    endfunction

    task automatic setRow(int r, string name, logic [8*maxBytes-1:0] seq, int len,
                          bit gap, int hold);
        rowName[r] = name;
        rowSeq[r]  = seq;
        rowLen[r]  = len;
        rowGap[r]  = gap;
        rowHold[r] = hold;
    endtask

    // Expected stores from the instruction rules with state carried across rows
    task automatic modelRow(int r);
        matMulPkg::instrByteT b;
        int                   i;
        rowExpCnt[r] = 0;
        i = 0;
        while (i < rowLen[r]) begin
            b = byteAt(r, i);
            i++;
            case (b[7:4])
                matMulPkg::opAssign: begin
                    case (b[3:0])
                        matMulPkg::varC1: mC1 = byteAt(r, i);
                        matMulPkg::varC2: mC2 = byteAt(r, i);
                        matMulPkg::varC3: mC3 = byteAt(r, i);
                        default:          ;
                    endcase
                    i++; // Skip the immediate
                end
                matMulPkg::opMove: begin
                    case (b[3:0])
                        matMulPkg::varP:  mP  = mAc;
                        matMulPkg::varT:  mT  = mAc;
                        matMulPkg::varC1: mC1 = mAc;
                        default:          ;
                    endcase
                end
                matMulPkg::opSet: if (b[3:0] == matMulPkg::varC1) mAc = mC1;
                matMulPkg::opAdd: begin
                    if (b[3:0] == matMulPkg::varT) mAc = mAc + mT;
                    if (b[3:0] == matMulPkg::varM2) mAc = mAc + mM2;
                end
                matMulPkg::opMul: if (b[3:0] == matMulPkg::varP) mAc = mP * mAc;
                matMulPkg::opInc: begin
                    case (b[3:0])
                        matMulPkg::varC2: mC2 = mC2 + 1;
                        matMulPkg::varC3: mC3 = mC3 + 1;
                        matMulPkg::varM2: mM2 = mM2 + 1;
                        default:          ;
                    endcase
                end
                matMulPkg::opReset: begin
                    if (b[3:0] == matMulPkg::varAll) begin
                        mT  = '0;
                        mM2 = '0;
                        mAc = '0;
                    end
                end
                matMulPkg::opStore: begin
                    rowExp[r][rowExpCnt[r]] = matMulPkg::storeRecT'({mC3, mT});
                    rowExpCnt[r]++;
                end
                default: ;
            endcase
        end
    endtask

    task automatic buildTable();
        mAc = '0;
        mP  = '0;
        mT  = '0;
        mC1 = '0;
        mC2 = '0;
        mC3 = '0;
        mM2 = '0;
        setRow(0, "assignStore", 56'h10_5A_30_24_12_33_80, 7, 1'b0, 0);
        setRow(1, "addMulWrap", 96'h10_91_30_23_24_44_24_80_30_53_24_80, 12, 1'b0, 0);
        setRow(2, "incReset", 64'h65_65_45_24_62_80_76_80, 8, 1'b0, 0);
        setRow(3, "backPressure", 112'h12_40_80_62_80_62_80_10_77_30_24_80_62_80, 14,
               1'b0, 60);
        // Undefined variants 0x60 0x2F 0x4F 0x70 0x1F and opcode 0x9A
        setRow(4, "randomGaps",
               168'h11_0F_61_10_C8_30_60_2F_4F_9A_24_12_E0_80_44_24_80_70_80_1F_55,
               21, 1'b1, 0);
        for (int r = 0; r < numRows; r++) begin
            modelRow(r);
        end
    endtask

    // Source side of the instruction channel that never sends beyond its credits
    task automatic sendBytes(int r);
        int i;
        int idle;
        bit skip;
        i = 0;
        idle = 0;
        while (i < rowLen[r]) begin
            @(posedge Clk);
            #1;
            instrValid = 1'b0;
            skip = rowGap[r] && (($random(seed) & 3) == 0);
            if (!skip && (`MATMUL_INSTR_DEPTH - bytesSent + creditPulses > 0)) begin
                instrValid = 1'b1;
                instrByte  = byteAt(r, i);
                i++;
                bytesSent++;
                idle = 0;
            end else if (!skip) begin
                idle++;
                if (idle > waitLimit) begin
                    $display("Timeout in %s: instruction credits never came back", rowName[r]);
                    abortRun();
                end
            end
        end
        @(posedge Clk);
        #1;
        instrValid = 1'b0;
    endtask

    // Sink side returns credits once the hold time has run out
    task automatic returnCredits(int r, int rowStart);
        int cycle;
        int heldMax;
        cycle = 0;
        heldMax = (rowExpCnt[r] < `MATMUL_STORE_CREDITS) ? rowExpCnt[r] : `MATMUL_STORE_CREDITS;
        forever begin
            @(posedge Clk);
            #1;
            storeCredit = 1'b0;
            if ((received.size() - rowStart >= rowExpCnt[r]) &&
                (creditsReturned == received.size())) break;
            if (cycle == rowHold[r] && rowHold[r] > 0) begin
                compareCredits({rowName[r], " records while credits held"}, heldMax,
                               received.size() - rowStart);
            end
            if (cycle >= rowHold[r] && creditsReturned < received.size()) begin
                storeCredit = 1'b1;
                creditsReturned++;
            end
            cycle++;
            if (cycle > rowHold[r] + waitLimit) begin
                $display("Timeout in %s: expected store records never arrived", rowName[r]);
                abortRun();
            end
        end
    endtask

    task automatic runRow(int r);
        int rowStart;
        rowStart = received.size();
        fork
            sendBytes(r);
            returnCredits(r, rowStart);
        join
        for (int k = 0; k < rowExpCnt[r]; k++) begin
            compareStore(rowName[r], rowExp[r][k], received[rowStart + k]);
        end
    endtask

    initial begin
        int drain;
        int totalExp;
        seed            = 32'h6f1e;
        rstN            = 1'b0;
        instrValid      = 1'b0;
        instrByte       = '0;
        storeCredit     = 1'b0;
        bytesSent       = 0;
        creditPulses    = 0;
        creditsReturned = 0;
        totalExp        = 0;
        buildTable();
        repeat (3) @(posedge Clk);
        #1;
        rstN = 1'b1;
        for (int r = 0; r < numRows; r++) begin
            runRow(r);
            totalExp += rowExpCnt[r];
        end
        drain = 0;
        while (creditPulses < bytesSent) begin
            @(posedge Clk);
            drain++;
            if (drain > waitLimit) begin
                $display("Timeout: instruction credits for the last bytes never came back");
                abortRun();
            end
        end
        repeat (8) @(posedge Clk); // Room for any stray store record
        compareCredits("instrCredit pulses", bytesSent, creditPulses);
        compareCredits("store record count", totalExp, received.size());
        $display("Verification passed");
        $finish;
    end

endmodule

// File: matMulCore.f
+incdir+.
matMulPkg.sv
creditFifo.sv
instrDecoder.sv
execUnit.sv
storePort.sv
matMulCore.sv
matMulCore_tb.sv

// File: Bender.yml
package:
  name: matMulCore

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - matMulPkg.sv
      - creditFifo.sv
      - instrDecoder.sv
      - execUnit.sv
      - storePort.sv
      - matMulCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - matMulCore_tb.sv
